//--- audio_pkg.sv
package audio_pkg;

  ////////////////////////////////////////////////////////////
  // Sample and frame types
  ////////////////////////////////////////////////////////////

  localparam int SAMPLE_BITS = 16;                 // Only word length supported

  typedef logic signed [SAMPLE_BITS-1:0] sample_t;

  // One stereo frame, left channel in the upper half
  typedef struct packed {
    sample_t left;
    sample_t right;
  } audio_frame_t;

  ////////////////////////////////////////////////////////////
  // I2S slot geometry
  ////////////////////////////////////////////////////////////

  localparam int SLOT_BITS = 32;                   // Bit clocks per LR half period

  typedef logic [4:0] slot_cnt_t;                  // Bit position in a slot

  ////////////////////////////////////////////////////////////
  // Playback FIFO
  ////////////////////////////////////////////////////////////

  localparam int FIFO_DEPTH = 8;                   // Frames held

  typedef logic [2:0] fifo_ptr_t;
  typedef logic [3:0] fifo_cnt_t;                  // Needs to reach FIFO_DEPTH

  // Test tone, square wave between TONE_HIGH and zero
  localparam sample_t TONE_HIGH     = 16'h1fff;
  localparam int      TONE_HALF_BIT = 6;           // 128 frame period

  typedef logic [7:0] tone_cnt_t;

  // Playback serializer FSM
  typedef enum logic [1:0] {
    SER_IDLE,
    SER_LEFT,
    SER_RIGHT
  } ser_state_t;

endpackage

//--- audio_frame_fifo.sv
`timescale 1ns/100ps

module audio_frame_fifo import audio_pkg::*; (
  input  logic         ac_bclk,
  input  logic         locked,
  input  logic         play_wr,       // Host write strobe
  input  logic         fifo_rd,       // Pop head frame
  input  audio_frame_t play_frame,
  output audio_frame_t fifo_frame,    // Head frame, fall-through
  output logic         fifo_empty,
  output logic         play_overflow  // Sticky
);

  audio_frame_t mem [FIFO_DEPTH];

  fifo_ptr_t wr_ptr_q;
  fifo_ptr_t rd_ptr_q;
  fifo_cnt_t count_q;
  logic      overflow_q;

  logic fifo_full;
  logic wr_en;
  logic rd_en;

  assign fifo_full  = (count_q == fifo_cnt_t'(FIFO_DEPTH));
  assign fifo_empty = (count_q == '0);

  assign wr_en = play_wr & ~fifo_full;  // Write into full FIFO is dropped
  assign rd_en = fifo_rd & ~fifo_empty; // Pop when empty ignored

  assign fifo_frame    = mem[rd_ptr_q];
  assign play_overflow = overflow_q;

  // Frame storage
  always_ff @(posedge ac_bclk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= play_frame;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers, fill count, overflow flag
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ac_bclk or negedge locked) begin
    if (!locked) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps at depth 8
      if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;         // Both or neither
      endcase
      if (play_wr && fifo_full) begin
        overflow_q <= 1'b1;
      end
    end
  end

endmodule

//--- audio_tone_source.sv
`timescale 1ns/100ps

module audio_tone_source import audio_pkg::*; (
  input  logic         ac_bclk,
  input  logic         locked,
  input  logic         test_mode,
  input  logic         frame_req,   // From serializer, once per left slot
  input  audio_frame_t fifo_frame,
  input  logic         fifo_empty,
  output logic         fifo_rd,
  output audio_frame_t src_frame,
  output logic         src_empty
);

  tone_cnt_t    tone_cnt_q;  // Frames played in test mode
  sample_t      tone_level;
  audio_frame_t tone_frame;

  // High for the first half of the period
  assign tone_level = tone_cnt_q[TONE_HALF_BIT] ? '0 : TONE_HIGH;

  always_comb begin
    tone_frame.left  = tone_level;
    tone_frame.right = tone_level;
  end

  ////////////////////////////////////////////////////////////
  // Source select
  ////////////////////////////////////////////////////////////
  assign fifo_rd   = frame_req & ~test_mode;          // FIFO untouched in test mode
  assign src_frame = test_mode ? tone_frame : fifo_frame;
  assign src_empty = ~test_mode & fifo_empty;         // Tone never runs dry

  // Tone counter, test mode requests only
  always_ff @(posedge ac_bclk or negedge locked) begin
    if (!locked) begin
      tone_cnt_q <= '0;
    end else if (frame_req && test_mode) begin
      tone_cnt_q <= tone_cnt_q + 1'b1;
    end
  end

endmodule

//--- i2s_playback_serializer.sv
`timescale 1ns/100ps

module i2s_playback_serializer import audio_pkg::*; (
  input  logic         ac_bclk,
  input  logic         locked,
  input  logic         ac_pblrc,       // Low for left, high for right
  input  audio_frame_t src_frame,
  input  logic         src_empty,
  output logic         frame_req,      // One cycle, start of left slot
  output logic         ac_pbdat,
  output logic         ac_muten,       // High releases CODEC mute
  output logic         play_underrun   // Sticky
);

  ser_state_t state_q;

  logic                 lr_q;           // Registered LR clock
  logic                 lr_fall;
  logic                 lr_rise;
  logic [SLOT_BITS-1:0] shift_q;
  sample_t              right_hold_q;   // Right sample waits for its slot
  audio_frame_t         load_frame;
  logic                 muten_q;
  logic                 underrun_q;

  ////////////////////////////////////////////////////////////
  // LR edge detect
  ////////////////////////////////////////////////////////////
  assign lr_fall = lr_q & ~ac_pblrc;   // Left slot begins
  assign lr_rise = ~lr_q & ac_pblrc;   // Right slot begins

  assign frame_req = lr_fall;

  // Silence when the source has nothing
  assign load_frame = src_empty ? '0 : src_frame;

  assign ac_pbdat      = shift_q[SLOT_BITS-1];  // MSB lands one bclk after LR change
  assign ac_muten      = muten_q;
  assign play_underrun = underrun_q;

  // Right sample held until the rising LR edge
  always_ff @(posedge ac_bclk) begin
    if (lr_fall) begin
      right_hold_q <= load_frame.right;
    end
  end

  ////////////////////////////////////////////////////////////
  // FSM, shift register, status flags
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ac_bclk or negedge locked) begin
    if (!locked) begin
      state_q    <= SER_IDLE;
      lr_q       <= 1'b0;
      shift_q    <= '0;
      muten_q    <= 1'b0;
      underrun_q <= 1'b0;
    end else begin
      lr_q <= ac_pblrc;

      case (state_q)
        SER_IDLE:  if (lr_fall) state_q <= SER_LEFT;   // Sync to first left slot
        SER_LEFT:  if (lr_rise) state_q <= SER_RIGHT;
        SER_RIGHT: if (lr_fall) state_q <= SER_LEFT;
        default:   state_q <= SER_IDLE;
      endcase

      // Sample in upper half, zeros trail it
      if (lr_fall) begin
        shift_q <= {load_frame.left, {(SLOT_BITS-SAMPLE_BITS){1'b0}}};
      end else if (lr_rise && state_q == SER_LEFT) begin
        shift_q <= {right_hold_q, {(SLOT_BITS-SAMPLE_BITS){1'b0}}};
      end else begin
        shift_q <= {shift_q[SLOT_BITS-2:0], 1'b0};
      end

      if (lr_fall) begin
        if (src_empty) begin
          underrun_q <= 1'b1;
        end else begin
          muten_q <= 1'b1;   // First real frame, unmute for good
        end
      end
    end
  end

endmodule

//--- i2s_record_deserializer.sv
`timescale 1ns/100ps

module i2s_record_deserializer import audio_pkg::*; (
  input  logic         ac_bclk,
  input  logic         locked,
  input  logic         ac_reclrc,   // Low for left, high for right
  input  logic         ac_recdat,
  output audio_frame_t rec_frame,
  output logic         rec_valid    // One cycle per stereo frame
);

  logic         lr_q;
  logic         lr_edge;
  logic         lr_fall;
  slot_cnt_t    bit_cnt_q;     // Saturates at end of slot
  slot_cnt_t    bit_pos;       // Position of the current bit
  logic         take_bit;
  logic         last_bit;
  sample_t      left_q;
  sample_t      right_q;
  logic         left_full_q;   // Complete left slot seen
  logic         right_full_q;  // Complete right slot after it
  audio_frame_t rec_frame_q;
  logic         rec_valid_q;

  ////////////////////////////////////////////////////////////
  // Edge detect and bit position
  ////////////////////////////////////////////////////////////
  assign lr_edge = lr_q ^ ac_reclrc;
  assign lr_fall = lr_q & ~ac_reclrc;

  assign bit_pos  = lr_edge ? '0 : bit_cnt_q;   // Edge cycle carries the MSB
  assign take_bit = (bit_pos < slot_cnt_t'(SAMPLE_BITS));
  assign last_bit = (bit_pos == slot_cnt_t'(SAMPLE_BITS - 1));

  assign rec_frame = rec_frame_q;
  assign rec_valid = rec_valid_q;

  // Sample capture, channel picked by LR level
  always_ff @(posedge ac_bclk) begin
    if (take_bit) begin
      if (ac_reclrc) right_q <= {right_q[SAMPLE_BITS-2:0], ac_recdat};
      else           left_q  <= {left_q[SAMPLE_BITS-2:0], ac_recdat};
    end
    if (lr_fall) begin
      rec_frame_q.left  <= left_q;    // Previous pair, before new MSB lands
      rec_frame_q.right <= right_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // Counter, frame flags, output strobe
  ////////////////////////////////////////////////////////////
  always_ff @(posedge ac_bclk or negedge locked) begin
    if (!locked) begin
      lr_q         <= 1'b0;
      bit_cnt_q    <= '1;         // Idle until a real edge
      left_full_q  <= 1'b0;
      right_full_q <= 1'b0;
      rec_valid_q  <= 1'b0;
    end else begin
      lr_q <= ac_reclrc;
      if (lr_edge) begin
        bit_cnt_q <= slot_cnt_t'(1);
      end else if (bit_cnt_q != '1) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (take_bit && last_bit) begin
        if (!ac_reclrc)       left_full_q  <= 1'b1;
        else if (left_full_q) right_full_q <= 1'b1;
      end
      rec_valid_q <= lr_fall & right_full_q;   // No partial first frame
    end
  end

endmodule

//--- audio_unit_top.sv
`timescale 1ns/100ps

module audio_unit_top import audio_pkg::*; (
  input  logic         ac_bclk,        // From CODEC, clock master
  input  logic         locked,
  input  logic         ac_pblrc,
  input  logic         ac_reclrc,
  input  logic         ac_recdat,
  input  logic         test_mode,      // Square wave instead of FIFO
  input  logic         play_wr,
  input  audio_frame_t play_frame,
  output logic         ac_pbdat,
  output logic         ac_muten,
  output logic         play_underrun,
  output logic         play_overflow,
  output logic         rec_valid,
  output audio_frame_t rec_frame
);

  audio_frame_t fifo_frame;
  audio_frame_t src_frame;
  logic         fifo_empty;
  logic         fifo_rd;
  logic         src_empty;
  logic         frame_req;

  ////////////////////////////////////////////////////////////
  // Playback path, FIFO to tone select to serializer
  ////////////////////////////////////////////////////////////
  audio_frame_fifo u_fifo (
    .ac_bclk, .locked, .play_wr, .fifo_rd, .play_frame,
    .fifo_frame, .fifo_empty, .play_overflow
  );

  audio_tone_source u_tone (
    .ac_bclk, .locked, .test_mode, .frame_req,
    .fifo_frame, .fifo_empty, .fifo_rd, .src_frame, .src_empty
  );

  i2s_playback_serializer u_ser (
    .ac_bclk, .locked, .ac_pblrc, .src_frame, .src_empty,
    .frame_req, .ac_pbdat, .ac_muten, .play_underrun
  );

  // Record path
  i2s_record_deserializer u_deser (
    .ac_bclk, .locked, .ac_reclrc, .ac_recdat,
    .rec_frame, .rec_valid
  );

endmodule

//--- tb_audio_unit.sv
`timescale 1ns/100ps

module tb_audio_unit import audio_pkg::*; ();

  localparam int N_PLAY = 6;
  localparam int N_REC  = 6;
  localparam int N_OVF  = FIFO_DEPTH + 2;
  localparam int N_TONE = 140;

  // Frames per test plus slot alignment
  localparam int TEST_FRAMES = (N_PLAY + 1) + (2 + 1) + (FIFO_DEPTH + 1) + (N_REC + 2)
                               + (N_TONE + 4);
  localparam int TIMEOUT_CYC = TEST_FRAMES * 2 * SLOT_BITS * 6 / 5;  // Two slots each and 20%

  logic         ac_bclk, locked, ac_pblrc, ac_reclrc, ac_recdat;
  logic         test_mode, play_wr;
  logic         ac_pbdat, ac_muten, play_underrun, play_overflow, rec_valid;
  audio_frame_t play_frame, rec_frame;

  audio_frame_t play_tab [N_PLAY];   // Playback stimulus = expected capture
  audio_frame_t rec_tab [N_REC];
  audio_frame_t ovf_tab [N_OVF];
  audio_frame_t cap_q [$];           // Frames rebuilt from ac_pbdat
  audio_frame_t rec_send_q [$];      // Frames the CODEC still has to record
  audio_frame_t rec_cur;
  sample_t      cap_word, cap_left, rec_bits;
  logic         lrclk, lr_run, have_left, rec_on, rec_last;
  int           phase, rec_cnt, err_cnt, err_mark, pass_cnt, fail_cnt, cyc;
  integer       seed = 32'h911;

  audio_unit_top dut (.*);

  initial begin
    ac_bclk = 1'b0;
    forever #5 ac_bclk = ~ac_bclk;
  end

  always @(posedge ac_bclk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYC);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // CODEC model, LR master, playback capture, record source
  ////////////////////////////////////////////////////////////
  always @(negedge ac_bclk) begin
    if (lr_run) begin
      // DUT bit here is what the CODEC latches on the next rising edge
      if (phase < SAMPLE_BITS) begin
        cap_word = {cap_word[SAMPLE_BITS-2:0], ac_pbdat};
        if (phase == SAMPLE_BITS - 1 && !lrclk) begin
          cap_left  = cap_word;
          have_left = 1'b1;
        end else if (phase == SAMPLE_BITS - 1 && have_left) begin
          cap_q.push_back({cap_left, cap_word});   // Left then right
          have_left = 1'b0;
        end
      end
      if (phase == SLOT_BITS - 1) begin
        phase = 0;
        lrclk = ~lrclk;
        if (!lrclk) begin
          rec_cur = '0;                            // Silence when nothing queued
          if (rec_send_q.size() > 0) rec_cur = rec_send_q.pop_front();
        end
        rec_bits = lrclk ? rec_cur.right : rec_cur.left;
      end else begin
        phase = phase + 1;
      end
      ac_pblrc  = lrclk;                           // Both LR clocks aligned
      ac_reclrc = lrclk;
      ac_recdat = rec_bits[SAMPLE_BITS-1];         // MSB with the LR change
      rec_bits  = rec_bits << 1;
    end
  end

  // Record strobe monitor
  always @(negedge ac_bclk) begin
    if (rec_valid && rec_last) begin
      $display("rec_valid stayed high for more than one cycle at %0t", $time);
      err_cnt++;
    end
    rec_last = rec_valid;
    if (rec_valid && rec_on) begin
      if (rec_cnt < N_REC) compare("rec_frame", rec_tab[rec_cnt], rec_frame);
      else $display("Extra rec_valid strobe at %0t after the last record frame", $time);
      if (rec_cnt >= N_REC) err_cnt++;
      rec_cnt++;
    end
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == err_mark) pass_cnt++;
    else fail_cnt++;
    $display("test %s %s", name, (err_cnt == err_mark) ? "ok" : "failed");
    err_mark = err_cnt;
  endtask

  task automatic wait_slot(input logic level);   // Rising edge right after an LR change
    @(posedge ac_bclk);
    while (phase != 0 || lrclk != level) @(posedge ac_bclk);
  endtask

  task automatic wait_frames(input int n);
    while (cap_q.size() < n) @(posedge ac_bclk);
  endtask

  task automatic drive_wr(input audio_frame_t f);
    @(negedge ac_bclk);
    play_frame = f;
    play_wr    = 1'b1;
  endtask

  task automatic end_wr();
    @(negedge ac_bclk);
    play_wr = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    locked     = 1'b0;
    test_mode  = 1'b0;
    play_wr    = 1'b0;
    play_frame = '0;
    ac_pblrc   = 1'b0;
    ac_reclrc  = 1'b0;
    ac_recdat  = 1'b0;
    lrclk      = 1'b0;
    lr_run     = 1'b0;
    phase      = SLOT_BITS - 1;   // First run cycle toggles LR
    have_left  = 1'b0;
    rec_on     = 1'b0;
    rec_last   = 1'b0;
    rec_bits   = '0;
    rec_cur    = '0;
    for (int i = 0; i < N_OVF; i++) begin
      if (i < N_PLAY) play_tab[i] = $random(seed);
      if (i < N_REC) rec_tab[i] = $random(seed);
      ovf_tab[i] = $random(seed);
    end
    repeat (2) @(posedge ac_bclk);
    @(negedge ac_bclk);
    locked = 1'b1;

    repeat (2) @(negedge ac_bclk);                 // LR clocks still stopped
    compare("ac_pbdat", 0, 32'(ac_pbdat));
    compare("ac_muten", 0, 32'(ac_muten));
    compare("rec_valid", 0, 32'(rec_valid));
    compare("play_underrun", 0, 32'(play_underrun));
    compare("play_overflow", 0, 32'(play_overflow));
    end_test("reset");

    drive_wr(play_tab[0]);                          // Queued before the first left slot
    end_wr();
    @(posedge ac_bclk);
    lr_run = 1'b1;
    for (int i = 1; i < N_PLAY; i++) begin
      wait_slot(1'b0);                              // Head frame just popped
      drive_wr(play_tab[i]);
      end_wr();
    end
    wait_frames(N_PLAY);
    for (int i = 0; i < N_PLAY; i++)
      compare("ac_pbdat frame", play_tab[i], cap_q[i]);
    compare("ac_muten", 1, 32'(ac_muten));
    compare("play_underrun", 0, 32'(play_underrun));
    end_test("playback");

    cap_q.delete();                                 // FIFO drained now
    wait_frames(2);
    compare("ac_pbdat frame", 0, cap_q[0]);
    compare("ac_pbdat frame", 0, cap_q[1]);
    compare("play_underrun", 1, 32'(play_underrun));
    end_test("underrun");

    wait_slot(1'b1);
    repeat (SLOT_BITS / 2 + 4) @(posedge ac_bclk);
    lr_run = 1'b0;                                  // Paused mid right slot
    for (int i = 0; i < N_OVF; i++)
      drive_wr(ovf_tab[i]);
    end_wr();
    compare("play_overflow", 1, 32'(play_overflow));
    cap_q.delete();
    @(posedge ac_bclk);
    lr_run = 1'b1;
    wait_frames(FIFO_DEPTH);
    for (int i = 0; i < FIFO_DEPTH; i++)
      compare("ac_pbdat frame", ovf_tab[i], cap_q[i]);
    end_test("overflow");

    for (int i = 0; i < N_REC; i++)
      rec_send_q.push_back(rec_tab[i]);
    wait_slot(1'b0);                                // First table frame goes out
    wait_slot(1'b1);                                // Stale pair already strobed
    rec_on = 1'b1;
    while (rec_cnt < N_REC) @(posedge ac_bclk);
    wait_slot(1'b1);
    rec_on = 1'b0;
    compare("rec_valid count", N_REC, rec_cnt);
    end_test("record");

    wait_slot(1'b0);
    drive_wr(play_tab[0]);                          // Must survive test mode
    drive_wr(play_tab[1]);
    end_wr();
    test_mode = 1'b1;
    wait_slot(1'b0);                                // Tone frame 0 requested
    cap_q.delete();
    wait_frames(N_TONE);
    for (int n = 0; n < N_TONE; n++)
      compare("ac_pbdat frame", n[TONE_HALF_BIT] ? 32'h0 : {TONE_HIGH, TONE_HIGH}, cap_q[n]);
    cap_q.delete();
    @(negedge ac_bclk);
    test_mode = 1'b0;
    wait_frames(2);
    compare("ac_pbdat frame", play_tab[0], cap_q[0]);
    compare("ac_pbdat frame", play_tab[1], cap_q[1]);
    end_test("test mode");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- sources.f
audio_pkg.sv
audio_frame_fifo.sv
audio_tone_source.sv
i2s_playback_serializer.sv
i2s_record_deserializer.sv
audio_unit_top.sv
tb_audio_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, status follows the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module tb_audio_unit \
  -f sources.f -o sim_audio || exit 1
out=$(./obj_dir/sim_audio)
echo "$out"
echo "$out" | grep -qx "=== PASS ===" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
